// ==== src/uno_pkg.sv ====
`default_nettype none

package uno_pkg;

    // 0 red, 1 yellow, 2 green, 3 blue
    typedef logic [1:0] colour_t;

    // faces 0..9 are number cards
    typedef logic [3:0] face_t;

    // up to 31 cards in hand
    typedef logic [4:0] count_t;

    typedef struct packed {
        colour_t colour;
        face_t   face;
    } card_t;

    localparam face_t FACE_SKIP           = 4'd10;
    localparam face_t FACE_REVERSE        = 4'd11;
    localparam face_t FACE_DRAW_TWO       = 4'd12;
    localparam face_t FACE_WILD           = 4'd13;
    localparam face_t FACE_WILD_DRAW_FOUR = 4'd14;

    localparam count_t INIT_HAND = 5'd7;      // cards dealt on init

    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,       // waiting for a command
        ST_DEAL   = 3'd1,       // pulling the starting hand
        ST_DECIDE = 3'd2,       // search result is evaluated here
        ST_DRAW   = 3'd3,       // no match, one card from the dealer
        ST_DONE   = 3'd4        // turn_done cycle
    } player_state_t;

endpackage

`default_nettype wire

// ==== src/hand_store.sv ====
`default_nettype none
`timescale 1ns/1ps

module hand_store #(
    parameter int MAX_HAND = 16
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                clear,
    input  logic                                ins_valid,
    input  uno_pkg::card_t                      ins_card,
    input  logic                                rem_valid,
    input  logic [$clog2(MAX_HAND)-1:0]         rem_slot,
    output uno_pkg::card_t [MAX_HAND-1:0]       slots,
    output logic [MAX_HAND-1:0]                 slot_valid,
    output uno_pkg::count_t                     hand_count,
    output logic                                hand_full
);

    localparam int SLOT_W = $clog2(MAX_HAND);

    typedef logic [SLOT_W-1:0] slot_idx_t;

    slot_idx_t free_slot;
    logic      free_found;
    logic      ins_ok;
    logic      rem_ok;

    // lowest empty slot, scanned downwards so the last hit wins
    always_comb begin
        free_found = 1'b0;
        free_slot  = '0;
        for (int i = MAX_HAND - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                free_found = 1'b1;
                free_slot  = slot_idx_t'(i);
            end
        end
    end

    assign ins_ok = ins_valid && free_found;            // dropped when full
    assign rem_ok = rem_valid && slot_valid[rem_slot];

    assign hand_full = (hand_count == uno_pkg::count_t'(MAX_HAND));

    // card payload only, validity lives in slot_valid
    always_ff @(posedge clk) begin
        if (ins_ok) begin
            slots[free_slot] <= ins_card;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slot_valid <= '0;
            hand_count <= '0;
        end else if (clear) begin
            slot_valid <= '0;
            hand_count <= '0;
        end else begin
            if (ins_ok) begin
                slot_valid[free_slot] <= 1'b1;
            end
            if (rem_ok) begin
                slot_valid[rem_slot] <= 1'b0;               // others stay put
            end
            hand_count <= hand_count + uno_pkg::count_t'(ins_ok)
                          - uno_pkg::count_t'(rem_ok);
        end
    end

endmodule

`default_nettype wire

// ==== src/match_finder.sv ====
`default_nettype none
`timescale 1ns/1ps

module match_finder #(
    parameter int MAX_HAND = 16
) (
    input  uno_pkg::card_t [MAX_HAND-1:0]   slots,
    input  logic [MAX_HAND-1:0]             slot_valid,
    input  uno_pkg::card_t                  top_card,
    output logic                            found,
    output logic [$clog2(MAX_HAND)-1:0]     found_slot
);

    localparam int SLOT_W = $clog2(MAX_HAND);

    typedef logic [SLOT_W-1:0] slot_idx_t;

    typedef struct packed {
        logic      hit;
        slot_idx_t slot;
    } pick_t;

    logic                top_wild;
    logic [MAX_HAND-1:0] colour_hit;
    logic [MAX_HAND-1:0] face_hit;
    logic [MAX_HAND-1:0] wild_hit;
    logic [MAX_HAND-1:0] wd4_hit;
    pick_t               colour_pick;
    pick_t               face_pick;
    pick_t               wild_pick;
    pick_t               wd4_pick;

    // lowest set bit of a hit vector
    function automatic pick_t lowest_hit(input logic [MAX_HAND-1:0] hits);
        pick_t pick;
        pick = '0;
        for (int i = MAX_HAND - 1; i >= 0; i--) begin
            if (hits[i]) begin
                pick.hit  = 1'b1;
                pick.slot = slot_idx_t'(i);
            end
        end
        return pick;
    endfunction

    // a wild on the table only accepts wilds
    assign top_wild = (top_card.face == uno_pkg::FACE_WILD) ||
                      (top_card.face == uno_pkg::FACE_WILD_DRAW_FOUR);

    for (genvar i = 0; i < MAX_HAND; i++) begin : g_slot
        logic card_wild;

        assign card_wild = (slots[i].face == uno_pkg::FACE_WILD) ||
                           (slots[i].face == uno_pkg::FACE_WILD_DRAW_FOUR);

        assign colour_hit[i] = slot_valid[i] && !card_wild && !top_wild &&
                               (slots[i].colour == top_card.colour);
        assign face_hit[i]   = slot_valid[i] && !card_wild && !top_wild &&
                               (slots[i].face == top_card.face);
        assign wild_hit[i]   = slot_valid[i] && (slots[i].face == uno_pkg::FACE_WILD);
        assign wd4_hit[i]    = slot_valid[i] &&
                               (slots[i].face == uno_pkg::FACE_WILD_DRAW_FOUR);
    end

    assign colour_pick = lowest_hit(colour_hit);
    assign face_pick   = lowest_hit(face_hit);
    assign wild_pick   = lowest_hit(wild_hit);
    assign wd4_pick    = lowest_hit(wd4_hit);

    // colour, then face, then wild, then wild draw four
    always_comb begin
        if (colour_pick.hit) begin
            found      = 1'b1;
            found_slot = colour_pick.slot;
        end else if (face_pick.hit) begin
            found      = 1'b1;
            found_slot = face_pick.slot;
        end else if (wild_pick.hit) begin
            found      = 1'b1;
            found_slot = wild_pick.slot;
        end else begin
            found      = wd4_pick.hit;
            found_slot = wd4_pick.slot;
        end
    end

endmodule

`default_nettype wire

// ==== src/turn_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module turn_ctrl #(
    parameter int MAX_HAND = 16
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            init,
    input  logic                            start,
    input  logic                            skip,
    input  uno_pkg::card_t                  top_card,
    input  logic                            draw_valid,
    input  uno_pkg::card_t                  draw_card,
    input  uno_pkg::card_t [MAX_HAND-1:0]   slots,
    input  logic                            found,
    input  logic [$clog2(MAX_HAND)-1:0]     found_slot,
    input  uno_pkg::count_t                 hand_count,
    input  logic                            hand_full,
    output logic                            draw_req,
    output logic                            play_valid,
    output uno_pkg::card_t                  play_card,
    output logic                            turn_done,
    output logic                            clear,
    output logic                            ins_valid,
    output uno_pkg::card_t                  ins_card,
    output logic                            rem_valid,
    output logic [$clog2(MAX_HAND)-1:0]     rem_slot,
    output uno_pkg::card_t                  held_top
);

    uno_pkg::player_state_t state;
    uno_pkg::player_state_t state_nxt;

    logic cmd_init;
    logic cmd_start;
    logic cmd_skip;
    logic take;
    logic last_deal;

    // commands only count in idle, init > start > skip
    assign cmd_init  = (state == uno_pkg::ST_IDLE) && init;
    assign cmd_start = (state == uno_pkg::ST_IDLE) && !init && start;
    assign cmd_skip  = (state == uno_pkg::ST_IDLE) && !init && !start && skip;

    assign draw_req  = (state == uno_pkg::ST_DEAL) || (state == uno_pkg::ST_DRAW);
    assign take      = draw_req && draw_valid;
    assign turn_done = (state == uno_pkg::ST_DONE);

    // hand was cleared on init, so hand_count is the number dealt so far
    assign last_deal = (hand_count == uno_pkg::INIT_HAND - 5'd1);

    assign clear     = cmd_init;
    assign ins_valid = take;
    assign ins_card  = draw_card;
    assign rem_valid = (state == uno_pkg::ST_DECIDE) && found;
    assign rem_slot  = found_slot;

    always_comb begin
        state_nxt = state;
        case (state)
            uno_pkg::ST_IDLE: begin
                if (cmd_init) begin
                    state_nxt = uno_pkg::ST_DEAL;
                end else if (cmd_start) begin
                    state_nxt = uno_pkg::ST_DECIDE;
                end else if (cmd_skip) begin
                    state_nxt = uno_pkg::ST_DONE;
                end
            end
            uno_pkg::ST_DEAL: begin
                if (take && last_deal) begin
                    state_nxt = uno_pkg::ST_DONE;
                end
            end
            uno_pkg::ST_DECIDE: begin
                if (found || hand_full) begin
                    state_nxt = uno_pkg::ST_DONE;       // play, or no room to draw
                end else begin
                    state_nxt = uno_pkg::ST_DRAW;
                end
            end
            uno_pkg::ST_DRAW: begin
                if (take) begin
                    state_nxt = uno_pkg::ST_DONE;
                end
            end
            uno_pkg::ST_DONE: begin
                state_nxt = uno_pkg::ST_IDLE;
            end
            default: begin
                state_nxt = uno_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= uno_pkg::ST_IDLE;
            play_valid <= 1'b0;
        end else begin
            state      <= state_nxt;
            play_valid <= rem_valid;    // same edge that empties the slot
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_start) begin
            held_top <= top_card;
        end
        if (rem_valid) begin
            play_card <= slots[found_slot];
        end
    end

endmodule

`default_nettype wire

// ==== src/uno_player.sv ====
`default_nettype none
`timescale 1ns/1ps

module uno_player #(
    parameter int MAX_HAND = 16
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            init,
    input  logic            start,
    input  logic            skip,
    input  uno_pkg::card_t  top_card,
    input  logic            draw_valid,
    input  uno_pkg::card_t  draw_card,
    output logic            draw_req,
    output logic            play_valid,
    output uno_pkg::card_t  play_card,
    output logic            turn_done,
    output uno_pkg::count_t hand_count
);

    localparam int SLOT_W = $clog2(MAX_HAND);

    uno_pkg::card_t [MAX_HAND-1:0] slots;
    logic [MAX_HAND-1:0]           slot_valid;
    logic                          hand_full;
    logic                          clear;
    logic                          ins_valid;
    uno_pkg::card_t                ins_card;
    logic                          rem_valid;
    logic [SLOT_W-1:0]             rem_slot;
    uno_pkg::card_t                held_top;   // top card of the current turn
    logic                          found;
    logic [SLOT_W-1:0]             found_slot;

    turn_ctrl #(
        .MAX_HAND   (MAX_HAND)
    ) u_turn_ctrl (
        .clk        (clk),
        .reset      (reset),
        .init       (init),
        .start      (start),
        .skip       (skip),
        .top_card   (top_card),
        .draw_valid (draw_valid),
        .draw_card  (draw_card),
        .slots      (slots),
        .found      (found),
        .found_slot (found_slot),
        .hand_count (hand_count),
        .hand_full  (hand_full),
        .draw_req   (draw_req),
        .play_valid (play_valid),
        .play_card  (play_card),
        .turn_done  (turn_done),
        .clear      (clear),
        .ins_valid  (ins_valid),
        .ins_card   (ins_card),
        .rem_valid  (rem_valid),
        .rem_slot   (rem_slot),
        .held_top   (held_top)
    );

    hand_store #(
        .MAX_HAND   (MAX_HAND)
    ) u_hand_store (
        .clk        (clk),
        .reset      (reset),
        .clear      (clear),
        .ins_valid  (ins_valid),
        .ins_card   (ins_card),
        .rem_valid  (rem_valid),
        .rem_slot   (rem_slot),
        .slots      (slots),
        .slot_valid (slot_valid),
        .hand_count (hand_count),
        .hand_full  (hand_full)
    );

    match_finder #(
        .MAX_HAND   (MAX_HAND)
    ) u_match_finder (
        .slots      (slots),
        .slot_valid (slot_valid),
        .top_card   (held_top),
        .found      (found),
        .found_slot (found_slot)
    );

endmodule

`default_nettype wire

// ==== tests/uno_player_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module uno_player_checker #(
    parameter int MAX_HAND = 16
) (
    input logic            clk,
    input logic            reset,
    input logic            draw_req,
    input logic            play_valid,
    input logic            turn_done,
    input uno_pkg::count_t hand_count
);

    // a turn either plays or draws, never both
    req_vs_play: assert property (@(posedge clk) disable iff (reset)
        !(draw_req && play_valid))
        else $error("draw_req and play_valid high together");

    play_one_cycle: assert property (@(posedge clk) disable iff (reset)
        play_valid |=> !play_valid)
        else $error("play_valid longer than one cycle");

    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        turn_done |=> !turn_done)
        else $error("turn_done longer than one cycle");

    count_in_range: assert property (@(posedge clk) disable iff (reset)
        hand_count <= uno_pkg::count_t'(MAX_HAND))
        else $error("hand_count above MAX_HAND");

endmodule

bind uno_player uno_player_checker #(
    .MAX_HAND   (MAX_HAND)
) u_checker (
    .clk        (clk),
    .reset      (reset),
    .draw_req   (draw_req),
    .play_valid (play_valid),
    .turn_done  (turn_done),
    .hand_count (hand_count)
);

`default_nettype wire

// ==== tests/tb_uno_player.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_uno_player;

    localparam int MAX_HAND       = 16;
    localparam int NUM_STEPS      = 10;
    localparam int NUM_DECK       = 15;
    localparam int TIMEOUT_CYCLES = NUM_STEPS * 40 + 10;

    localparam logic [1:0] CMD_INIT  = 2'd0;
    localparam logic [1:0] CMD_START = 2'd1;
    localparam logic [1:0] CMD_SKIP  = 2'd2;

    typedef struct packed {
        logic [1:0]      cmd;
        logic            poke;          // extra start pulse while dealing
        uno_pkg::card_t  top;
        logic [2:0]      n_draw;        // cards the dealer hands out
        logic            exp_play;
        uno_pkg::card_t  exp_card;
        uno_pkg::count_t exp_count;
    } step_t;

    logic            clk;
    logic            reset;
    logic            init;
    logic            start;
    logic            skip;
    uno_pkg::card_t  top_card;
    logic            draw_valid;
    uno_pkg::card_t  draw_card;
    logic            draw_req;
    logic            play_valid;
    uno_pkg::card_t  play_card;
    logic            turn_done;
    uno_pkg::count_t hand_count;

    uno_pkg::card_t deal_q[$];
    int             takes_total;
    int             deck_ptr;
    int             errors;

    // dealt in order: 7 for the first deal, 1 drawn, 7 for the second deal
    uno_pkg::card_t deck [NUM_DECK] = '{6'h03, 6'h15, 6'h27, 6'h09, 6'h0E, 6'h0D, 6'h18,
                                        6'h36,
                                        6'h21, 6'h22, 6'h04, 6'h39, 6'h1A, 6'h0C, 6'h0D};

    step_t steps [NUM_STEPS] = '{
        '{CMD_INIT,  1'b0, 6'h00, 3'd7, 1'b0, 6'h00, 5'd7},
        '{CMD_START, 1'b0, 6'h01, 3'd0, 1'b1, 6'h03, 5'd6},    // colour, lower of two reds
        '{CMD_START, 1'b0, 6'h35, 3'd0, 1'b1, 6'h15, 5'd5},    // face only
        '{CMD_START, 1'b0, 6'h32, 3'd0, 1'b1, 6'h0D, 5'd4},    // wild before wild draw four
        '{CMD_START, 1'b0, 6'h0D, 3'd0, 1'b1, 6'h0E, 5'd3},
        '{CMD_START, 1'b0, 6'h31, 3'd1, 1'b0, 6'h00, 5'd4},    // nothing fits, draw
        '{CMD_START, 1'b0, 6'h30, 3'd0, 1'b1, 6'h36, 5'd3},    // the drawn card
        '{CMD_SKIP,  1'b0, 6'h00, 3'd0, 1'b0, 6'h00, 5'd3},
        '{CMD_INIT,  1'b1, 6'h00, 3'd7, 1'b0, 6'h00, 5'd7},
        '{CMD_START, 1'b0, 6'h2C, 3'd0, 1'b1, 6'h21, 5'd6}
    };

    uno_player #(
        .MAX_HAND   (MAX_HAND)
    ) u_uno_player (
        .clk        (clk),
        .reset      (reset),
        .init       (init),
        .start      (start),
        .skip       (skip),
        .top_card   (top_card),
        .draw_valid (draw_valid),
        .draw_card  (draw_card),
        .draw_req   (draw_req),
        .play_valid (play_valid),
        .play_card  (play_card),
        .turn_done  (turn_done),
        .hand_count (hand_count)
    );

    always #5 clk = ~clk;

    task automatic check_card(input string name, input uno_pkg::card_t got,
                              input uno_pkg::card_t exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input uno_pkg::count_t got,
                               input uno_pkg::count_t exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic note_fail(input string what);
        $display("t=%0t %s", $time, what);
        errors++;
    endtask

    task automatic run_step(input int idx);
        step_t          st;
        int             lat;
        int             plays;
        int             takes_at_start;
        int             errors_at_start;
        logic           seen_req;
        uno_pkg::card_t got_card;
        st = steps[idx];
        errors_at_start = errors;
        takes_at_start  = takes_total;
        for (int i = 0; i < int'(st.n_draw); i++) begin
            deal_q.push_back(deck[deck_ptr]);
            deck_ptr++;
        end
        @(negedge clk);
        top_card = st.top;
        init     = (st.cmd == CMD_INIT);
        start    = (st.cmd == CMD_START);
        skip     = (st.cmd == CMD_SKIP);
        lat      = 0;
        plays    = 0;
        seen_req = 1'b0;
        got_card = '0;
        do begin
            @(negedge clk);
            lat++;
            init  = 1'b0;
            skip  = 1'b0;
            start = st.poke && (lat == 3);      // must be ignored in ST_DEAL
            if (draw_req) seen_req = 1'b1;
            if (play_valid) begin
                plays++;
                got_card = play_card;
            end
        end while (!turn_done);
        check_count("hand_count", hand_count, st.exp_count);
        if (st.exp_play) begin
            if (plays != 1 || lat != 2) begin
                note_fail($sformatf("expected one play two cycles after start, saw %0d in %0d",
                                    plays, lat));
            end else begin
                check_card("play_card", got_card, st.exp_card);
            end
        end else if (plays != 0) begin
            note_fail("a card was played where none was expected");
        end
        if (st.cmd == CMD_SKIP && lat != 1) note_fail("skip did not finish after one cycle");
        if ((st.n_draw != 3'd0) != seen_req) note_fail("draw_req did not follow the expected draw");
        if (takes_total - takes_at_start != int'(st.n_draw)) begin
            note_fail($sformatf("dealer handed out %0d cards, expected %0d",
                                takes_total - takes_at_start, st.n_draw));
        end
        $display("step %0d: %s", idx, (errors == errors_at_start) ? "ok" : "mismatch");
    endtask

    // answers each request after 0 to 4 idle cycles
    initial begin : dealer
        int wait_cycles;
        void'($urandom(39745));
        draw_valid  = 1'b0;
        draw_card   = '0;
        takes_total = 0;
        wait_cycles = $urandom % 5;
        forever begin
            @(negedge clk);
            if (draw_valid) begin
                draw_valid  = 1'b0;
                wait_cycles = $urandom % 5;
            end else if (draw_req && deal_q.size() > 0) begin
                if (wait_cycles > 0) begin
                    wait_cycles--;
                end else begin
                    draw_card  = deal_q.pop_front();
                    draw_valid = 1'b1;
                    takes_total++;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, a step never reached turn_done", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        init     = 1'b0;
        start    = 1'b0;
        skip     = 1'b0;
        top_card = '0;
        deck_ptr = 0;
        errors   = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < NUM_STEPS; i++) begin
            run_step(i);
        end
        $display("%0d steps, %0d errors", NUM_STEPS, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/uno_pkg.sv
src/hand_store.sv
src/match_finder.sv
src/turn_ctrl.sv
src/uno_player.sv
tests/uno_player_checker.sv
tests/tb_uno_player.sv

// ==== run.sh ====
#!/bin/sh
# build and run the UNO player testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module tb_uno_player -Mdir obj_dir -o sim_uno_player
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_uno_player)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TB PASSED$"; then
    exit 0
fi
exit 1
